// File: Makefile
BUILD = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module ticTacToeTb -Mdir $(BUILD) -f sim.f
	@out="$$(./$(BUILD)/VticTacToeTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf $(BUILD)

// File: hdl/boardPkg.sv
package boardPkg;

	// ======================================================================
	// cells and positions
	// ======================================================================

	typedef enum logic [1:0]
	{
		cellEmpty = 2'b00,
		cellX = 2'b01,
		cellO = 2'b10
	} cellState;

	// row 0 is the top row
	typedef struct packed
	{
		logic [1:0] row;
		logic [1:0] col;
	} boardPos;

	// cell of row r and column c sits at index r * 3 + c
	typedef cellState [8:0] boardCells;

	typedef struct packed
	{
		logic done;
		logic draw;
		cellState winner;
	} gameResult;

	// ======================================================================
	// board constants
	// ======================================================================

	localparam int boardSize = 3;
	localparam logic [1:0] lastRowCol = 2'(boardSize - 1);
	localparam boardPos startPos = '{row: 2'd1, col: 2'd1};
	localparam boardCells emptyBoard = '{default: cellEmpty};

	// rows, then columns, then the two diagonals
	localparam int lineCount = 8;
	localparam logic [0:7][0:2][3:0] winLines = '{
		'{4'd0, 4'd1, 4'd2},
		'{4'd3, 4'd4, 4'd5},
		'{4'd6, 4'd7, 4'd8},
		'{4'd0, 4'd3, 4'd6},
		'{4'd1, 4'd4, 4'd7},
		'{4'd2, 4'd5, 4'd8},
		'{4'd0, 4'd4, 4'd8},
		'{4'd2, 4'd4, 4'd6}
	};

	function automatic logic [3:0] posIndex(boardPos pos);
		return 4'(pos.row * boardSize + pos.col);
	endfunction

endpackage

// File: hdl/keyCodesPkg.sv
package keyCodesPkg;

	// ======================================================================
	// keyboard scan codes of one byte each
	// ======================================================================

	localparam logic [7:0] keyW = 8'h1D;
	localparam logic [7:0] keyA = 8'h1C;
	localparam logic [7:0] keyS = 8'h1B;
	localparam logic [7:0] keyD = 8'h23;
	localparam logic [7:0] keyR = 8'h2D;
	localparam logic [7:0] keyEnter = 8'h5A;

	// a release sends this prefix and then the code of the released key
	localparam logic [7:0] keyBreak = 8'hF0;

	// ======================================================================
	// decoded commands
	// ======================================================================

	typedef enum logic [2:0]
	{
		cmdUp,
		cmdDown,
		cmdLeft,
		cmdRight,
		cmdPlace,
		cmdClear
	} commandKind;

	typedef struct packed
	{
		logic valid;
		commandKind kind;
	} keyCommand;

endpackage

// File: hdl/keyDecoder.sv
module keyDecoder
(
	input logic flagReset,
	input logic reset,
	input logic [7:0] keyData,
	input logic keyStrobe,
	output keyCodesPkg::keyCommand command
);

	logic breakPending;
	logic lookupHit;
	keyCodesPkg::commandKind lookupKind;

	// codes missing from the scan-code table are ignored
	always_comb
	begin
		lookupHit = 1'b1;
		lookupKind = keyCodesPkg::cmdUp;
		case (keyData)
			keyCodesPkg::keyW: lookupKind = keyCodesPkg::cmdUp;
			keyCodesPkg::keyS: lookupKind = keyCodesPkg::cmdDown;
			keyCodesPkg::keyA: lookupKind = keyCodesPkg::cmdLeft;
			keyCodesPkg::keyD: lookupKind = keyCodesPkg::cmdRight;
			keyCodesPkg::keyEnter: lookupKind = keyCodesPkg::cmdPlace;
			keyCodesPkg::keyR: lookupKind = keyCodesPkg::cmdClear;
			default: lookupHit = 1'b0;
		endcase
	end

	// the byte after a break prefix names the released key and is swallowed
	always_ff @(posedge flagReset)
	begin
		if (reset)
		begin
			breakPending <= 1'b0;
			command.valid <= 1'b0;
		end
		else
		begin
			command.valid <= 1'b0;
			if (keyStrobe)
			begin
				if (breakPending)
				begin
					breakPending <= 1'b0;
				end
				else if (keyData == keyCodesPkg::keyBreak)
				begin
					breakPending <= 1'b1;
				end
				else
				begin
					command.valid <= lookupHit;
					command.kind <= lookupKind;
				end
			end
		end
	end

endmodule

// File: hdl/lineJudge.sv
module lineJudge
(
	input logic flagReset,
	input logic reset,
	input boardPkg::boardCells board,
	output boardPkg::gameResult result
);

	boardPkg::cellState lineMark;
	logic boardFull;
	boardPkg::gameResult nextResult;

	// a line counts when its three cells hold the same mark
	always_comb
	begin
		lineMark = boardPkg::cellEmpty;
		for (int l = 0; l < boardPkg::lineCount; l++)
		begin
			if (board[boardPkg::winLines[l][0]] != boardPkg::cellEmpty
				&& board[boardPkg::winLines[l][0]] == board[boardPkg::winLines[l][1]]
				&& board[boardPkg::winLines[l][1]] == board[boardPkg::winLines[l][2]])
			begin
				lineMark = board[boardPkg::winLines[l][0]];
			end
		end
	end

	always_comb
	begin
		boardFull = 1'b1;
		for (int i = 0; i < boardPkg::boardSize * boardPkg::boardSize; i++)
		begin
			if (board[i] == boardPkg::cellEmpty)
			begin
				boardFull = 1'b0;
			end
		end
	end

	// a line takes priority, since the last mark can fill the board and win
	always_comb
	begin
		nextResult.done = 1'b0;
		nextResult.draw = 1'b0;
		nextResult.winner = boardPkg::cellEmpty;
		if (lineMark != boardPkg::cellEmpty)
		begin
			nextResult.done = 1'b1;
			nextResult.winner = lineMark;
		end
		else if (boardFull)
		begin
			nextResult.done = 1'b1;
			nextResult.draw = 1'b1;
		end
	end

	always_ff @(posedge flagReset)
	begin
		if (reset)
		begin
			result.done <= 1'b0;
			result.draw <= 1'b0;
			result.winner <= boardPkg::cellEmpty;
		end
		else
		begin
			result <= nextResult;
		end
	end

endmodule

// File: hdl/moveController.sv
module moveController
(
	input logic flagReset,
	input logic reset,
	input keyCodesPkg::keyCommand command,
	input logic gameDone,
	output boardPkg::boardPos cursor,
	output boardPkg::boardCells board,
	output boardPkg::cellState turn
);

	logic [3:0] cursorIndex;
	logic cursorFree;
	logic placeOk;

	always_comb
	begin
		cursorIndex = boardPkg::posIndex(cursor);
		cursorFree = (board[cursorIndex] == boardPkg::cellEmpty);
	end

	// a placement needs an empty cell and a game still in progress
	always_comb
	begin
		placeOk = command.valid && (command.kind == keyCodesPkg::cmdPlace);
		placeOk = placeOk && cursorFree && !gameDone;
	end

	// ======================================================================
	// cursor
	// ======================================================================

	// moves stop at the edges instead of wrapping
	always_ff @(posedge flagReset)
	begin
		if (reset)
		begin
			cursor <= boardPkg::startPos;
		end
		else if (command.valid)
		begin
			case (command.kind)
				keyCodesPkg::cmdUp:
				begin
					if (cursor.row != 2'd0)
					begin
						cursor.row <= cursor.row - 2'd1;
					end
				end
				keyCodesPkg::cmdDown:
				begin
					if (cursor.row != boardPkg::lastRowCol)
					begin
						cursor.row <= cursor.row + 2'd1;
					end
				end
				keyCodesPkg::cmdLeft:
				begin
					if (cursor.col != 2'd0)
					begin
						cursor.col <= cursor.col - 2'd1;
					end
				end
				keyCodesPkg::cmdRight:
				begin
					if (cursor.col != boardPkg::lastRowCol)
					begin
						cursor.col <= cursor.col + 2'd1;
					end
				end
				keyCodesPkg::cmdClear:
				begin
					cursor <= boardPkg::startPos;
				end
				default:
				begin
					cursor <= cursor;
				end
			endcase
		end
	end

	// ======================================================================
	// board and turn
	// ======================================================================

	always_ff @(posedge flagReset)
	begin
		if (reset)
		begin
			board <= boardPkg::emptyBoard;
			turn <= boardPkg::cellX;
		end
		else if (command.valid && (command.kind == keyCodesPkg::cmdClear))
		begin
			board <= boardPkg::emptyBoard;
			turn <= boardPkg::cellX;
		end
		else if (placeOk)
		begin
			board[cursorIndex] <= turn;
			// turns only alternate on a placement that went through
			if (turn == boardPkg::cellX)
			begin
				turn <= boardPkg::cellO;
			end
			else
			begin
				turn <= boardPkg::cellX;
			end
		end
	end

endmodule

// File: hdl/ticTacToeTop.sv
module ticTacToeTop
(
	input logic flagReset,
	input logic reset,
	input logic [7:0] keyData,
	input logic keyStrobe,
	output boardPkg::boardPos cursor,
	output boardPkg::boardCells board,
	output boardPkg::cellState turn,
	output boardPkg::gameResult result
);

	keyCodesPkg::keyCommand command;

	keyDecoder keyDecoder_i
	(
		.flagReset(flagReset),
		.reset(reset),
		.keyData(keyData),
		.keyStrobe(keyStrobe),
		.command(command)
	);

	// the finished flag from the judge blocks further placements
	moveController moveController_i
	(
		.flagReset(flagReset),
		.reset(reset),
		.command(command),
		.gameDone(result.done),
		.cursor(cursor),
		.board(board),
		.turn(turn)
	);

	lineJudge lineJudge_i
	(
		.flagReset(flagReset),
		.reset(reset),
		.board(board),
		.result(result)
	);

endmodule

// File: sim.f
hdl/keyCodesPkg.sv
hdl/boardPkg.sv
hdl/keyDecoder.sv
hdl/moveController.sv
hdl/lineJudge.sv
hdl/ticTacToeTop.sv
tests/clockGen.sv
tests/ticTacToeTb.sv

// File: tests/clockGen.sv
module clockGen
(
	output logic flagReset,
	output logic reset
);

	timeunit 1ns;
	timeprecision 100ps;

	// 40 ns period
	initial
	begin
		flagReset = 1'b0;
		forever #20 flagReset = ~flagReset;
	end

	// reset stays high over the first five rising edges
	initial
	begin
		reset = 1'b1;
		repeat (5) @(posedge flagReset);
		reset <= 1'b0;
	end

endmodule

// File: tests/ticTacToeTb.sv
module ticTacToeTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int waitLimit = 50;

	logic flagReset;
	logic reset;
	logic [7:0] keyData;
	logic keyStrobe;
	boardPkg::boardPos cursor;
	boardPkg::boardCells board;
	boardPkg::cellState turn;
	boardPkg::gameResult result;

	boardPkg::boardPos modelCursor;
	boardPkg::boardCells modelBoard;
	boardPkg::cellState modelTurn;
	boardPkg::gameResult modelResult;

	logic checkRequest;
	logic [2:0] checkPipe;
	logic [31:0] lfsrState;
	int errorCount;
	int testErrorBase;
	int testsPassed;
	int testsFailed;

	clockGen clockGen_i
	(
		.flagReset(flagReset),
		.reset(reset)
	);

	ticTacToeTop dut_i
	(
		.flagReset(flagReset),
		.reset(reset),
		.keyData(keyData),
		.keyStrobe(keyStrobe),
		.cursor(cursor),
		.board(board),
		.turn(turn),
		.result(result)
	);

	// ======================================================================
	// the result is due three edges after each strobe
	// ======================================================================

	always @(posedge flagReset)
	begin
		if (reset)
			checkPipe <= '0;
		else
			checkPipe <= {checkPipe[1:0], keyStrobe | checkRequest};
	end

	cursorMatches: assert property (@(posedge flagReset) disable iff (reset)
		checkPipe[2] |-> cursor == modelCursor)
	else
	begin
		errorCount++;
		$display("mismatch at %0t: cursor %h, expected %h", $time, cursor, modelCursor);
	end

	boardMatches: assert property (@(posedge flagReset) disable iff (reset)
		checkPipe[2] |-> board == modelBoard)
	else
	begin
		errorCount++;
		$display("mismatch at %0t: board %h, expected %h", $time, board, modelBoard);
	end

	turnMatches: assert property (@(posedge flagReset) disable iff (reset)
		checkPipe[2] |-> turn == modelTurn)
	else
	begin
		errorCount++;
		$display("mismatch at %0t: turn %h, expected %h", $time, turn, modelTurn);
	end

	resultMatches: assert property (@(posedge flagReset) disable iff (reset)
		checkPipe[2] |-> result == modelResult)
	else
	begin
		errorCount++;
		$display("mismatch at %0t: result %h, expected %h", $time, result, modelResult);
	end

	// ======================================================================
	// reference model
	// ======================================================================

	function automatic boardPkg::cellState lineOwner(input boardPkg::boardCells cells,
		input boardPkg::cellState owner, input int a, input int b, input int c);
		if (cells[a] != boardPkg::cellEmpty && cells[a] == cells[b] && cells[b] == cells[c])
			return cells[a];
		return owner;
	endfunction

	function automatic boardPkg::gameResult judgeModel(input boardPkg::boardCells cells);
		boardPkg::gameResult verdict;
		boardPkg::cellState owner;
		logic full;
		owner = boardPkg::cellEmpty;
		full = 1'b1;
		for (int k = 0; k < 3; k++)
		begin
			owner = lineOwner(cells, owner, 3 * k, 3 * k + 1, 3 * k + 2);
			owner = lineOwner(cells, owner, k, k + 3, k + 6);
		end
		owner = lineOwner(cells, owner, 0, 4, 8);
		owner = lineOwner(cells, owner, 2, 4, 6);
		for (int k = 0; k < 9; k++)
		begin
			if (cells[k] == boardPkg::cellEmpty)
				full = 1'b0;
		end
		verdict = '0;
		if (owner != boardPkg::cellEmpty)
		begin
			verdict.done = 1'b1;
			verdict.winner = owner;
		end
		else if (full)
		begin
			verdict.done = 1'b1;
			verdict.draw = 1'b1;
		end
		return verdict;
	endfunction

	task automatic resetModel();
		modelCursor = '{row: 2'd1, col: 2'd1};
		modelBoard = {9{boardPkg::cellEmpty}};
		modelTurn = boardPkg::cellX;
		modelResult = '0;
	endtask

	task automatic applyModel(input logic [7:0] code);
		int idx;
		idx = 3 * int'(modelCursor.row) + int'(modelCursor.col);
		case (code)
			keyCodesPkg::keyW:
			begin
				if (modelCursor.row != 2'd0)
					modelCursor.row = modelCursor.row - 2'd1;
			end
			keyCodesPkg::keyS:
			begin
				if (modelCursor.row != 2'd2)
					modelCursor.row = modelCursor.row + 2'd1;
			end
			keyCodesPkg::keyA:
			begin
				if (modelCursor.col != 2'd0)
					modelCursor.col = modelCursor.col - 2'd1;
			end
			keyCodesPkg::keyD:
			begin
				if (modelCursor.col != 2'd2)
					modelCursor.col = modelCursor.col + 2'd1;
			end
			keyCodesPkg::keyEnter:
			begin
				if (modelBoard[idx] == boardPkg::cellEmpty && !modelResult.done)
				begin
					modelBoard[idx] = modelTurn;
					modelTurn = (modelTurn == boardPkg::cellX) ? boardPkg::cellO : boardPkg::cellX;
				end
			end
			keyCodesPkg::keyR:
			begin
				resetModel();
			end
			default:
			begin
			end
		endcase
		modelResult = judgeModel(modelBoard);
	endtask

	// ======================================================================
	// stimulus
	// ======================================================================

	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ 32'h80200003;
		return state >> 1;
	endfunction

	task automatic takeBits(input int count, output logic [7:0] bits);
		bits = '0;
		for (int n = 0; n < count; n++)
		begin
			lfsrState = lfsrStep(lfsrState);
			bits = {bits[6:0], lfsrState[0]};
		end
	endtask

	// q stands for a code that the decoder does not know
	function automatic logic [7:0] keyFor(input byte letter);
		case (letter)
			"w": return keyCodesPkg::keyW;
			"a": return keyCodesPkg::keyA;
			"s": return keyCodesPkg::keyS;
			"d": return keyCodesPkg::keyD;
			"e": return keyCodesPkg::keyEnter;
			"r": return keyCodesPkg::keyR;
			default: return 8'h15;
		endcase
	endfunction

	task automatic sendByte(input logic [7:0] code);
		keyData <= code;
		keyStrobe <= 1'b1;
		@(posedge flagReset);
		keyStrobe <= 1'b0;
		repeat (4) @(posedge flagReset);
	endtask

	// press, then release; the extra cycle keeps model updates off check edges
	task automatic pressKey(input logic [7:0] code);
		applyModel(code);
		sendByte(code);
		sendByte(keyCodesPkg::keyBreak);
		sendByte(code);
		@(posedge flagReset);
	endtask

	task automatic playKeys(input string keys);
		for (int n = 0; n < keys.len(); n++)
		begin
			pressKey(keyFor(keys[n]));
		end
	endtask

	task automatic playRandom(input int count);
		logic [7:0] bits;
		string choices;
		choices = "wasdeeer";
		for (int n = 0; n < count; n++)
		begin
			takeBits(3, bits);
			pressKey(keyFor(choices[int'(bits[2:0])]));
		end
	endtask

	task automatic requestCheck();
		checkRequest <= 1'b1;
		@(posedge flagReset);
		checkRequest <= 1'b0;
	endtask

	task automatic waitResetDone();
		int cycles;
		cycles = 0;
		@(posedge flagReset);
		while (reset && cycles < waitLimit)
		begin
			@(posedge flagReset);
			cycles++;
		end
		if (reset)
		begin
			$display("timeout: reset still active after %0d cycles", cycles);
			$display("Testbench failed");
			$finish;
		end
	endtask

	task automatic waitChecksDone(input string testName);
		int cycles;
		cycles = 0;
		@(posedge flagReset);
		while (checkPipe != '0 && cycles < waitLimit)
		begin
			@(posedge flagReset);
			cycles++;
		end
		if (checkPipe != '0)
		begin
			$display("timeout: checks of test %s never completed", testName);
			$display("Testbench failed");
			$finish;
		end
	endtask

	task automatic finishTest(input string testName);
		int errors;
		waitChecksDone(testName);
		errors = errorCount - testErrorBase;
		testErrorBase = errorCount;
		if (errors == 0)
		begin
			testsPassed++;
			$display("test %s: ok", testName);
		end
		else
		begin
			testsFailed++;
			$display("test %s: %0d mismatches", testName, errors);
		end
	endtask

	initial
	begin
		keyData = 8'h00;
		keyStrobe = 1'b0;
		checkRequest = 1'b0;
		lfsrState = 32'h275559c2;
		errorCount = 0;
		testErrorBase = 0;
		testsPassed = 0;
		testsFailed = 0;
		resetModel();
		waitResetDone();

		requestCheck();
		finishTest("reset state");

		// saturate at every edge, then an unknown code
		playKeys("wwaasssddddqw");
		finishTest("movement");

		playKeys("reedeqe");
		finishTest("placement");

		playKeys("rwaesewdesewdesese");
		finishTest("row win");
		playKeys("reaeddeaaweddessaaede");
		finishTest("column win");
		playKeys("reweaesesddeae");
		finishTest("diagonal win");

		playKeys("rwaededesaeaeddesaeaedde");
		finishTest("draw");

		playRandom(40);
		playKeys("r");
		finishTest("random play");

		$display("%0d tests passed, %0d tests failed, %0d mismatches",
			testsPassed, testsFailed, errorCount);
		if (testsFailed == 0 && errorCount == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule
